// ==== include/arcade_io_cfg.svh ====
// Arcade wrapper configuration
`ifndef ARCADE_IO_CFG_SVH
`define ARCADE_IO_CFG_SVH

// ============================================================
// Audio
// ============================================================
`define CFG_DAC_WIDTH 10

// ============================================================
// Video
// ============================================================
`define CFG_COLOR_DEPTH 4   // Core colour bits per channel
`define CFG_VGA_DEPTH 6     // VGA colour bits per channel

// Slow enable divider, about 1.79 MHz from 25 MHz
`define CFG_SLOW_DIV 14

`endif

// ==== logic/arcade_pkg.sv ====
// Arcade wrapper types
`default_nettype none

package arcade_pkg;

	// ============================================================
	// PS/2 decoding
	// ============================================================
	typedef enum logic [1:0] {
		IDLE,       // Waiting for a sequence
		EXT,        // After E0
		BREAK,      // After F0
		EXT_BREAK   // After E0 F0
	} ps2_state_e;

	localparam logic [7:0] PREFIX_EXT = 8'hE0;
	localparam logic [7:0] PREFIX_BREAK = 8'hF0;

	// Scan codes used by the game
	typedef enum logic [7:0] {
		KEY_START1 = 8'h05,  // F1
		KEY_START2 = 8'h06,  // F2
		KEY_FIRE2 = 8'h11,   // Alt
		KEY_FIRE1 = 8'h29,   // Space
		KEY_LEFT = 8'h6B,
		KEY_DOWN = 8'h72,
		KEY_RIGHT = 8'h74,
		KEY_UP = 8'h75,
		KEY_COIN = 8'h76     // Esc
	} key_code_e;

	// Scanline dimming on odd lines
	typedef enum logic [1:0] {
		OFF,
		DIM25,
		DIM50,
		DIM75
	} scanline_e;

endpackage

`default_nettype wire

// ==== logic/buttons_if.sv ====
// Keyboard button bundle
`default_nettype none

interface buttons_if;
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire1;
	logic fire2;
	logic coin;
	logic start1;
	logic start2;

	// Decoder side
	modport src (output up, down, left, right, fire1, fire2, coin, start1, start2);

	// Mapper side
	modport dst (input up, down, left, right, fire1, fire2, coin, start1, start2);
endinterface

`default_nettype wire

// ==== logic/clock_enables.sv ====
// Core clock enable generator
`default_nettype none

`include "arcade_io_cfg.svh"

module clock_enables (
	input  wire  clk_sys,
	input  wire  rst,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_slow
);

	localparam int SLOW_W = $clog2(`CFG_SLOW_DIV);

	logic [1:0] phase;        // Fast enable phase
	logic [SLOW_W-1:0] slow_cnt;

	// ============================================================
	// Fast enables, 12 MHz and two 6 MHz phases
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			phase <= 2'd0;
			ce_12 <= 1'b0;
			ce_6p <= 1'b0;
			ce_6n <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			ce_12 <= ~phase[0];
			ce_6p <= (phase == 2'd0);
			ce_6n <= (phase == 2'd2);  // Half a 6 MHz period later
		end
	end

	// Slow enable, one pulse per divider period
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			slow_cnt <= '0;
			ce_slow <= 1'b0;
		end else begin
			ce_slow <= (slow_cnt == '0);
			if (slow_cnt == '0)
				slow_cnt <= SLOW_W'(`CFG_SLOW_DIV - 1);
			else
				slow_cnt <= slow_cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/ps2_key_decoder.sv ====
// PS/2 scan code decoder
`default_nettype none

module ps2_key_decoder (
	input  wire        clk_sys,
	input  wire        rst,
	input  wire  [7:0] key_data,
	input  wire        key_valid,
	buttons_if.src     btn
);

	arcade_pkg::ps2_state_e state;
	logic brk;    // F0 seen in this sequence
	logic ext;    // E0 seen in this sequence
	logic make;

	assign brk = (state == arcade_pkg::BREAK) || (state == arcade_pkg::EXT_BREAK);
	assign ext = (state == arcade_pkg::EXT) || (state == arcade_pkg::EXT_BREAK);
	assign make = ~brk;

	// ============================================================
	// Prefix tracking and button latches
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= arcade_pkg::IDLE;
			btn.up <= 1'b0;
			btn.down <= 1'b0;
			btn.left <= 1'b0;
			btn.right <= 1'b0;
			btn.fire1 <= 1'b0;
			btn.fire2 <= 1'b0;
			btn.coin <= 1'b0;
			btn.start1 <= 1'b0;
			btn.start2 <= 1'b0;
		end else if (key_valid) begin
			case (key_data)
				arcade_pkg::PREFIX_EXT: begin
					state <= brk ? arcade_pkg::EXT_BREAK : arcade_pkg::EXT;
				end
				arcade_pkg::PREFIX_BREAK: begin
					state <= ext ? arcade_pkg::EXT_BREAK : arcade_pkg::BREAK;
				end
				default: begin
					// Final byte ends the sequence whatever it is
					state <= arcade_pkg::IDLE;
					// Arrows normally carry E0, but plain codes count too
					case (key_data)
						arcade_pkg::KEY_UP: btn.up <= make;
						arcade_pkg::KEY_DOWN: btn.down <= make;
						arcade_pkg::KEY_LEFT: btn.left <= make;
						arcade_pkg::KEY_RIGHT: btn.right <= make;
						arcade_pkg::KEY_FIRE1: btn.fire1 <= make;
						arcade_pkg::KEY_FIRE2: btn.fire2 <= make;
						arcade_pkg::KEY_COIN: btn.coin <= make;
						arcade_pkg::KEY_START1: btn.start1 <= make;
						arcade_pkg::KEY_START2: btn.start2 <= make;
						default: begin
						end
					endcase
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/control_mapper.sv ====
// Player control mapper
`default_nettype none

module control_mapper (
	input  wire        clk_sys,
	input  wire        rst,
	buttons_if.dst     btn,
	input  wire  [5:0] joy0,
	input  wire  [5:0] joy1,
	input  wire        rotate,
	output logic [6:0] p1_n,
	output logic [6:0] p2_n,
	output logic       coin_n
);

	// Joystick bit positions
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT = 1;
	localparam int JOY_DOWN = 2;
	localparam int JOY_UP = 3;
	localparam int JOY_FIRE1 = 4;
	localparam int JOY_FIRE2 = 5;

	logic up, down, left, right;
	logic fire1, fire2;
	logic m_up, m_down, m_left, m_right;  // After rotation

	// ============================================================
	// Merge keyboard and both sticks
	// ============================================================
	always_comb begin
		up = btn.up | joy0[JOY_UP] | joy1[JOY_UP];
		down = btn.down | joy0[JOY_DOWN] | joy1[JOY_DOWN];
		left = btn.left | joy0[JOY_LEFT] | joy1[JOY_LEFT];
		right = btn.right | joy0[JOY_RIGHT] | joy1[JOY_RIGHT];
		fire1 = btn.fire1 | joy0[JOY_FIRE1] | joy1[JOY_FIRE1];
		fire2 = btn.fire2 | joy0[JOY_FIRE2] | joy1[JOY_FIRE2];

		if (rotate) begin
			// Quarter turn for a vertical cabinet
			m_up = left;
			m_down = right;
			m_left = down;
			m_right = up;
		end else begin
			m_up = up;
			m_down = down;
			m_left = left;
			m_right = right;
		end
	end

	// Active low vectors, start in the top bit
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			p1_n <= '1;
			p2_n <= '1;
			coin_n <= 1'b1;
		end else begin
			p1_n <= ~{btn.start1, fire2, fire1, m_left, m_right, m_up, m_down};
			p2_n <= ~{btn.start2, fire2, fire1, m_left, m_right, m_up, m_down};
			coin_n <= ~btn.coin;
		end
	end

endmodule

`default_nettype wire

// ==== logic/video_output.sv ====
// VGA output stage
`default_nettype none

`include "arcade_io_cfg.svh"

module video_output (
	input  wire                          clk_sys,
	input  wire                          rst,
	input  wire  [`CFG_COLOR_DEPTH-1:0]  r,
	input  wire  [`CFG_COLOR_DEPTH-1:0]  g,
	input  wire  [`CFG_COLOR_DEPTH-1:0]  b,
	input  wire                          hsync,
	input  wire                          vsync,
	input  wire                          hblank,
	input  wire                          vblank,
	input  arcade_pkg::scanline_e        scanlines,
	output logic [`CFG_VGA_DEPTH-1:0]    vga_r,
	output logic [`CFG_VGA_DEPTH-1:0]    vga_g,
	output logic [`CFG_VGA_DEPTH-1:0]    vga_b,
	output logic                         vga_hs,
	output logic                         vga_vs
);

	localparam int CD = `CFG_COLOR_DEPTH;
	localparam int VD = `CFG_VGA_DEPTH;

	logic hs_prev;
	logic line_odd;   // Low bit of the line count
	logic blank;

	assign blank = hblank | vblank;

	// Dim one channel and widen it to the VGA depth
	function automatic logic [VD-1:0] shade(input logic [CD-1:0] c, input logic dim,
		input arcade_pkg::scanline_e mode);
		logic [CD-1:0] d;
		d = c;
		if (dim) begin
			case (mode)
				arcade_pkg::DIM25: d = c - (c >> 2);
				arcade_pkg::DIM50: d = c >> 1;
				arcade_pkg::DIM75: d = c >> 2;
				default: d = c;
			endcase
		end
		return {d, d[CD-1 -: VD-CD]};  // Top bits repeated below
	endfunction

	// ============================================================
	// Line parity, counted on hsync rising edges
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hs_prev <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hs_prev <= hsync;
			if (vsync)
				line_odd <= 1'b0;
			else if (hsync && !hs_prev)
				line_odd <= ~line_odd;
		end
	end

	// Output register
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			vga_r <= blank ? '0 : shade(r, line_odd, scanlines);
			vga_g <= blank ? '0 : shade(g, line_odd, scanlines);
			vga_b <= blank ? '0 : shade(b, line_odd, scanlines);
			vga_hs <= ~hsync;   // Core syncs are active high
			vga_vs <= ~vsync;
		end
	end

endmodule

`default_nettype wire

// ==== logic/sigma_delta_dac.sv ====
// First order sigma-delta DAC
`default_nettype none

`include "arcade_io_cfg.svh"

module sigma_delta_dac (
	input  wire                         clk_sys,
	input  wire                         rst,
	input  wire  [`CFG_DAC_WIDTH-1:0]   sample,
	output logic                        dac_out
);

	localparam int W = `CFG_DAC_WIDTH;

	logic [W:0] acc;   // Residue plus carry

	// ============================================================
	// Accumulate and emit the carry
	// ============================================================
	// The residue starts just below full scale, so every aligned
	// window of 2^W cycles after reset carries exactly sample times
	always_ff @(posedge clk_sys) begin
		if (rst)
			acc <= {1'b0, {W{1'b1}}};
		else
			acc <= {1'b0, acc[W-1:0]} + {1'b0, sample};
	end

	assign dac_out = acc[W];   // Low in reset

endmodule

`default_nettype wire

// ==== logic/arcade_io_top.sv ====
// Arcade board wrapper
`default_nettype none

`include "arcade_io_cfg.svh"

module arcade_io_top (
	input  wire                          clk_sys,
	input  wire                          rst,
	// Keyboard and sticks
	input  wire  [7:0]                   key_data,
	input  wire                          key_valid,
	input  wire  [5:0]                   joy0,
	input  wire  [5:0]                   joy1,
	input  wire                          rotate,
	// Core video
	input  wire  [`CFG_COLOR_DEPTH-1:0]  r,
	input  wire  [`CFG_COLOR_DEPTH-1:0]  g,
	input  wire  [`CFG_COLOR_DEPTH-1:0]  b,
	input  wire                          hsync,
	input  wire                          vsync,
	input  wire                          hblank,
	input  wire                          vblank,
	input  arcade_pkg::scanline_e        scanlines,
	input  wire  [`CFG_DAC_WIDTH-1:0]    audio_sample,
	// Core enables
	output logic                         ce_12,
	output logic                         ce_6p,
	output logic                         ce_6n,
	output logic                         ce_slow,
	// Player inputs, active low
	output logic [6:0]                   p1_n,
	output logic [6:0]                   p2_n,
	output logic                         coin_n,
	// Board outputs
	output logic [`CFG_VGA_DEPTH-1:0]    vga_r,
	output logic [`CFG_VGA_DEPTH-1:0]    vga_g,
	output logic [`CFG_VGA_DEPTH-1:0]    vga_b,
	output logic                         vga_hs,
	output logic                         vga_vs,
	output logic                         audio_l,
	output logic                         audio_r
);

	buttons_if keys ();

	// ============================================================
	// Clocking and controls
	// ============================================================
	clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_12   (ce_12),
		.ce_6p   (ce_6p),
		.ce_6n   (ce_6n),
		.ce_slow (ce_slow)
	);

	ps2_key_decoder u_ps2_key_decoder (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.key_data  (key_data),
		.key_valid (key_valid),
		.btn       (keys)
	);

	control_mapper u_control_mapper (
		.clk_sys (clk_sys),
		.rst     (rst),
		.btn     (keys),
		.joy0    (joy0),
		.joy1    (joy1),
		.rotate  (rotate),
		.p1_n    (p1_n),
		.p2_n    (p2_n),
		.coin_n  (coin_n)
	);

	// ============================================================
	// Video and audio out
	// ============================================================
	video_output u_video_output (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.r         (r),
		.g         (g),
		.b         (b),
		.hsync     (hsync),
		.vsync     (vsync),
		.hblank    (hblank),
		.vblank    (vblank),
		.scanlines (scanlines),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	sigma_delta_dac u_sigma_delta_dac (
		.clk_sys (clk_sys),
		.rst     (rst),
		.sample  (audio_sample),
		.dac_out (audio_l)
	);

	assign audio_r = audio_l;   // Mono core

endmodule

`default_nettype wire

// ==== verif/arcade_io_tb.sv ====
// Arcade wrapper testbench
`default_nettype none

`include "arcade_io_cfg.svh"

module arcade_io_tb;

	localparam logic [7:0] EXT = 8'hE0;
	localparam logic [7:0] BRK = 8'hF0;
	localparam logic [7:0] UNKNOWN = 8'h1C;   // Not a game key
	localparam int KEY_ROWS = 21;
	localparam int VID_ROWS = 11;
	localparam int WATCHDOG_CYCLES = (KEY_ROWS + VID_ROWS) * 2048;

	// Key row holds byte count, up to three bytes, sticks, rotate and expected vectors
	typedef struct packed {
		logic [1:0]  n;
		logic [23:0] bytes;
		logic [5:0]  joy0;
		logic [5:0]  joy1;
		logic        rot;
		logic [6:0]  p1;
		logic [6:0]  p2;
		logic        coin;
	} key_row_t;

	typedef struct packed {
		logic [`CFG_COLOR_DEPTH-1:0] r, g, b;
		logic hb, vb;
		arcade_pkg::scanline_e mode;
		logic odd;                         // Line parity wanted
		logic [`CFG_VGA_DEPTH-1:0] er, eg, eb;
	} vid_row_t;

	localparam key_row_t KEY_TAB [KEY_ROWS] = '{
		'{2'd1, {arcade_pkg::KEY_START1, 16'h0}, 6'h00, 6'h00, 1'b0, 7'h3F, 7'h7F, 1'b1},
		'{2'd2, {EXT, arcade_pkg::KEY_UP, 8'h0}, 6'h00, 6'h00, 1'b0, 7'h3D, 7'h7D, 1'b1},
		'{2'd2, {BRK, arcade_pkg::KEY_START1, 8'h0}, 6'h00, 6'h00, 1'b0, 7'h7D, 7'h7D, 1'b1},
		'{2'd1, {arcade_pkg::KEY_COIN, 16'h0}, 6'h00, 6'h00, 1'b0, 7'h7D, 7'h7D, 1'b0},
		'{2'd1, {arcade_pkg::KEY_FIRE1, 16'h0}, 6'h00, 6'h00, 1'b0, 7'h6D, 7'h6D, 1'b0},
		'{2'd3, {EXT, BRK, arcade_pkg::KEY_UP}, 6'h00, 6'h00, 1'b0, 7'h6F, 7'h6F, 1'b0},
		'{2'd2, {BRK, arcade_pkg::KEY_COIN, 8'h0}, 6'h00, 6'h00, 1'b0, 7'h6F, 7'h6F, 1'b1},
		'{2'd1, {arcade_pkg::KEY_LEFT, 16'h0}, 6'h00, 6'h00, 1'b0, 7'h67, 7'h67, 1'b1},
		'{2'd1, {UNKNOWN, 16'h0}, 6'h00, 6'h00, 1'b0, 7'h67, 7'h67, 1'b1},
		'{2'd2, {BRK, UNKNOWN, 8'h0}, 6'h00, 6'h00, 1'b0, 7'h67, 7'h67, 1'b1},
		'{2'd0, 24'h0, 6'h00, 6'h00, 1'b1, 7'h6D, 7'h6D, 1'b1},   // Left shows as up
		'{2'd2, {BRK, arcade_pkg::KEY_LEFT, 8'h0}, 6'h00, 6'h00, 1'b0, 7'h6F, 7'h6F, 1'b1},
		'{2'd1, {arcade_pkg::KEY_START2, 16'h0}, 6'h00, 6'h00, 1'b0, 7'h6F, 7'h2F, 1'b1},
		'{2'd2, {BRK, arcade_pkg::KEY_FIRE1, 8'h0}, 6'h00, 6'h00, 1'b0, 7'h7F, 7'h3F, 1'b1},
		'{2'd3, {EXT, BRK, arcade_pkg::KEY_START2}, 6'h00, 6'h00, 1'b0, 7'h7F, 7'h7F, 1'b1},
		'{2'd2, {EXT, arcade_pkg::KEY_RIGHT, 8'h0}, 6'h00, 6'h00, 1'b0, 7'h7B, 7'h7B, 1'b1},
		'{2'd0, 24'h0, 6'h00, 6'h00, 1'b1, 7'h7E, 7'h7E, 1'b1},   // Right shows as down
		'{2'd3, {EXT, BRK, arcade_pkg::KEY_RIGHT}, 6'h00, 6'h00, 1'b0, 7'h7F, 7'h7F, 1'b1},
		'{2'd0, 24'h0, 6'h01, 6'h00, 1'b0, 7'h7B, 7'h7B, 1'b1},
		'{2'd0, 24'h0, 6'h00, 6'h20, 1'b0, 7'h5F, 7'h5F, 1'b1},
		'{2'd0, 24'h0, 6'h08, 6'h00, 1'b1, 7'h7B, 7'h7B, 1'b1}    // Up shows as right
	};

	localparam vid_row_t VID_TAB [VID_ROWS] = '{
		'{4'hF, 4'h8, 4'h1, 1'b0, 1'b0, arcade_pkg::OFF, 1'b0, 6'h3F, 6'h22, 6'h04},
		'{4'hF, 4'h8, 4'h1, 1'b0, 1'b0, arcade_pkg::OFF, 1'b1, 6'h3F, 6'h22, 6'h04},
		'{4'hC, 4'h7, 4'h3, 1'b0, 1'b0, arcade_pkg::DIM25, 1'b1, 6'h26, 6'h19, 6'h0C},
		'{4'hC, 4'h7, 4'h3, 1'b0, 1'b0, arcade_pkg::DIM25, 1'b0, 6'h33, 6'h1D, 6'h0C},
		'{4'hF, 4'hA, 4'h5, 1'b0, 1'b0, arcade_pkg::DIM50, 1'b0, 6'h3F, 6'h2A, 6'h15},
		'{4'hF, 4'hA, 4'h5, 1'b0, 1'b0, arcade_pkg::DIM50, 1'b1, 6'h1D, 6'h15, 6'h08},
		'{4'hF, 4'h8, 4'hE, 1'b0, 1'b0, arcade_pkg::DIM75, 1'b1, 6'h0C, 6'h08, 6'h0C},
		'{4'hF, 4'h8, 4'hE, 1'b0, 1'b0, arcade_pkg::DIM75, 1'b0, 6'h3F, 6'h22, 6'h3B},
		'{4'hF, 4'hF, 4'hF, 1'b1, 1'b0, arcade_pkg::DIM50, 1'b1, 6'h00, 6'h00, 6'h00},
		'{4'hF, 4'hF, 4'hF, 1'b0, 1'b1, arcade_pkg::OFF, 1'b0, 6'h00, 6'h00, 6'h00},
		'{4'h5, 4'h5, 4'h5, 1'b0, 1'b1, arcade_pkg::DIM75, 1'b1, 6'h00, 6'h00, 6'h00}
	};

	logic clk_sys = 1'b0;
	logic rst;
	logic [7:0] key_data;
	logic key_valid;
	logic [5:0] joy0, joy1;
	logic rotate;
	logic [`CFG_COLOR_DEPTH-1:0] r, g, b;
	logic hsync, vsync, hblank, vblank;
	arcade_pkg::scanline_e scanlines;
	logic [`CFG_DAC_WIDTH-1:0] audio_sample;
	logic ce_12, ce_6p, ce_6n, ce_slow;
	logic [6:0] p1_n, p2_n;
	logic coin_n;
	logic [`CFG_VGA_DEPTH-1:0] vga_r, vga_g, vga_b;
	logic vga_hs, vga_vs, audio_l, audio_r;

	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int error_mark = 0;

	arcade_io_top uut (.*);

	always #5 clk_sys = ~clk_sys;

	// ============================================================
	// Helpers and reference model
	// ============================================================
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;   // Drive and sample just after the edge
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != error_mark)
			failed_tests++;
		$display("Test %0d %s: %s", tests, name, (errors == error_mark) ? "ok" : "failed");
		error_mark = errors;
	endtask

	task automatic send_key(input logic [7:0] code);
		key_data = code;
		key_valid = 1'b1;
		next_cycle();
		key_valid = 1'b0;
	endtask

	// Keyboard mask uses the joystick bit order
	function automatic logic [6:0] map_vector(input logic start, input logic [5:0] kb,
		input logic [5:0] j0, input logic [5:0] j1, input logic rot);
		logic [5:0] m;
		logic up, down, left, right;
		m = kb | j0 | j1;
		up = rot ? m[1] : m[3];
		down = rot ? m[0] : m[2];
		left = rot ? m[2] : m[1];
		right = rot ? m[3] : m[0];
		return ~{start, m[5], m[4], left, right, up, down};
	endfunction

	// ============================================================
	// Stimulus
	// ============================================================
	initial begin
		int n12, n6p, n6n, nslow, overlap, ones;
		logic parity;
		logic [`CFG_DAC_WIDTH-1:0] s;
		void'($urandom(32'h3fb3_3693));
		rst = 1'b1;
		key_data = 8'h00;
		key_valid = 1'b0;
		joy0 = 6'h00;
		joy1 = 6'h00;
		rotate = 1'b0;
		{r, g, b} = '0;
		{hsync, vsync, hblank, vblank} = 4'b0000;
		scanlines = arcade_pkg::OFF;
		audio_sample = '0;
		repeat (10) next_cycle();

		// Reset state and enable counts over 56 cycles
		check("p1_n", p1_n, 7'h7F);
		check("p2_n", p2_n, 7'h7F);
		check("coin_n", coin_n, 1'b1);
		check("ce", {ce_12, ce_6p, ce_6n, ce_slow}, 4'h0);
		check("vga_sync", {vga_hs, vga_vs}, 2'b11);
		check("vga_rgb", {vga_r, vga_g, vga_b}, 0);
		check("audio_l", audio_l, 1'b0);
		rst = 1'b0;
		{n12, n6p, n6n, nslow, overlap} = '0;
		repeat (56) begin
			next_cycle();
			n12 += ce_12;
			n6p += ce_6p;
			n6n += ce_6n;
			nslow += ce_slow;
			overlap += ce_6p & ce_6n;
		end
		check("ce_12 count", n12, 56 / 2);
		check("ce_6p count", n6p, 56 / 4);
		check("ce_6n count", n6n, 56 / 4);
		check("ce_slow count", nslow, 56 / `CFG_SLOW_DIV);
		check("ce_6p and ce_6n overlap", overlap, 0);
		end_test("reset and enables");

		for (int i = 0; i < KEY_ROWS; i++) begin
			joy0 = KEY_TAB[i].joy0;
			joy1 = KEY_TAB[i].joy1;
			rotate = KEY_TAB[i].rot;
			for (int k = 0; k < KEY_TAB[i].n; k++)
				send_key(KEY_TAB[i].bytes[23 - 8 * k -: 8]);
			next_cycle();   // Mapper register
			check("p1_n", p1_n, KEY_TAB[i].p1);
			check("p2_n", p2_n, KEY_TAB[i].p2);
			check("coin_n", coin_n, KEY_TAB[i].coin);
		end
		end_test("key decoding");

		// Hold start1, fire2 and an extended down
		{joy0, joy1, rotate} = '0;
		send_key(arcade_pkg::KEY_START1);
		send_key(arcade_pkg::KEY_FIRE2);
		send_key(EXT);
		send_key(arcade_pkg::KEY_DOWN);
		repeat (24) begin
			joy0 = 6'($urandom);
			joy1 = 6'($urandom);
			rotate = 1'($urandom);
			next_cycle();
			check("p1_n", p1_n, map_vector(1'b1, 6'b100100, joy0, joy1, rotate));
			check("p2_n", p2_n, map_vector(1'b0, 6'b100100, joy0, joy1, rotate));
			check("coin_n", coin_n, 1'b1);
		end
		end_test("merge and rotation");

		// ============================================================
		// Video with line parity from hsync edges
		// ============================================================
		vsync = 1'b1;
		next_cycle();
		check("vga_vs", vga_vs, 1'b0);
		vsync = 1'b0;
		parity = 1'b0;
		for (int i = 0; i < VID_ROWS; i++) begin
			if (VID_TAB[i].odd != parity) begin
				hsync = 1'b1;
				next_cycle();
				check("vga_hs", vga_hs, 1'b0);
				hsync = 1'b0;
				parity = ~parity;
			end
			{r, g, b} = {VID_TAB[i].r, VID_TAB[i].g, VID_TAB[i].b};
			hblank = VID_TAB[i].hb;
			vblank = VID_TAB[i].vb;
			scanlines = VID_TAB[i].mode;
			next_cycle();
			check("vga_r", vga_r, VID_TAB[i].er);
			check("vga_g", vga_g, VID_TAB[i].eg);
			check("vga_b", vga_b, VID_TAB[i].eb);
			check("vga_sync", {vga_hs, vga_vs}, 2'b11);
		end

		// Vsync on an odd line brings back an even line
		vsync = 1'b1;
		next_cycle();
		check("vga_vs", vga_vs, 1'b0);
		vsync = 1'b0;
		{r, g, b} = {4'hF, 4'hA, 4'h5};
		{hblank, vblank} = 2'b00;
		scanlines = arcade_pkg::DIM50;
		next_cycle();
		check("vga_r", vga_r, 6'h3F);
		check("vga_g", vga_g, 6'h2A);
		check("vga_b", vga_b, 6'h15);
		end_test("video output");

		// Each sample starts from a fresh reset
		for (int i = 0; i < 6; i++) begin
			s = (i == 0) ? '0 : (i == 1) ? '1 : `CFG_DAC_WIDTH'($urandom);
			rst = 1'b1;
			audio_sample = s;
			next_cycle();
			rst = 1'b0;
			ones = 0;
			repeat (1 << `CFG_DAC_WIDTH) begin
				next_cycle();
				ones += audio_l;
				check("audio_r", audio_r, audio_l);
			end
			check("audio_l ones", ones, s);
		end
		end_test("audio dac");

		$display("Tests run %0d, failed %0d, mismatches %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== arcade_io.f ====
+incdir+include
logic/arcade_pkg.sv
logic/buttons_if.sv
logic/clock_enables.sv
logic/ps2_key_decoder.sv
logic/control_mapper.sv
logic/video_output.sv
logic/sigma_delta_dac.sv
logic/arcade_io_top.sv
verif/arcade_io_tb.sv

// ==== Makefile ====
TOP := arcade_io_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f arcade_io.f --top-module $(TOP) -o V$(TOP)

# Pass only when the testbench prints its pass line
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing -Wall -f arcade_io.f --top-module arcade_io_top

clean:
	rm -rf obj_dir
